/* Bender.yml */
package:
  name: ft_sim

sources:
  - files:
      - hdl/ft_sim_pkg.sv
      - hdl/ft_sim_cfg.sv
      - hdl/ft_host_tx.sv
      - hdl/ft_host_rx.sv
      - hdl/ft_sim_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_ft_sim.sv

/* hdl/ft_host_rx.sv */
// FPGA-to-host command parser of the FT2232 model.
// A byte is taken on each edge with TXE# low, OE# high and WR# low.
// Argument bit 4 set means a two-byte length follows, else bits 3..0 hold it.
// Data payload must count up from zero across commands; loopback is ignored.
// The first stopped payload byte is kept as the error code.
// A bad byte or unknown opcode latches a fault and closes TXE# until start_i.

`timescale 1ns/10ps

module ft_host_rx
    import ft_sim_pkg::*;
(
    input  logic  fifo_clk_o,
    input  logic  ft2232_reset_n_i,
    input  logic  start_i,
    input  logic  fifo_oe_n_i,
    input  logic  fifo_wr_n_i,
    input  byte_t fifo_data_i,
    output logic  fifo_txe_n_o,
    output logic  abort_o,
    output logic  stopped_o,
    output logic  test_done_o,
    output logic  fault_o,
    output byte_t error_code_o
);

    typedef enum logic [1:0] {
        RX_CMD,
        RX_LEN,
        RX_PAYLOAD,
        RX_IDLE
    } rx_state_e;

    rx_state_e state_q;
    fpga_cmd_e cmd_q;
    len_t      pay_cnt_q;
    byte_t     exp_q;
    logic      len_lo_q;
    logic      first_q;
    logic      wr_en;
    logic      long_len;
    len_t      short_len;
    len_t      full_len;

    assign wr_en     = !fifo_txe_n_o && fifo_oe_n_i && !fifo_wr_n_i;
    assign long_len  = (fifo_data_i[CMD_ARG_W-1:0] & LEN_FOLLOWS) != '0;
    assign short_len = {12'd0, fifo_data_i[3:0]};
    assign full_len  = {pay_cnt_q[15:8], fifo_data_i};

    // Idle only after a fault, so it doubles as the abort level
    assign fifo_txe_n_o = (state_q == RX_IDLE);
    assign abort_o      = fault_o;

    // ======================================================================
    // Parser
    // ======================================================================
    always_ff @(posedge fifo_clk_o or negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            state_q      <= RX_CMD;
            cmd_q        <= FPGA_DATA;
            pay_cnt_q    <= '0;
            exp_q        <= '0;
            len_lo_q     <= 1'b0;
            first_q      <= 1'b0;
            stopped_o    <= 1'b0;
            test_done_o  <= 1'b0;
            fault_o      <= 1'b0;
            error_code_o <= '0;
        end else begin
            stopped_o <= 1'b0;
            if (start_i) begin
                state_q     <= RX_CMD;
                exp_q       <= '0;
                fault_o     <= 1'b0;
                test_done_o <= 1'b0;
            end else if (wr_en) begin
                case (state_q)
                    RX_CMD: begin
                        first_q  <= 1'b1;
                        len_lo_q <= 1'b0;
                        case (fifo_data_i[7:5])
                            FPGA_DATA, FPGA_LOOPBACK, FPGA_STOPPED: begin
                                cmd_q <= fpga_cmd_e'(fifo_data_i[7:5]);
                                stopped_o <= (fifo_data_i[7:5] == FPGA_STOPPED);
                                if (long_len) begin
                                    state_q <= RX_LEN;
                                end else if (short_len != '0) begin
                                    pay_cnt_q <= short_len;
                                    state_q   <= RX_PAYLOAD;
                                end else if (fifo_data_i[7:5] == FPGA_STOPPED) begin
                                    // Stopped without payload ends the test here
                                    test_done_o <= 1'b1;
                                end
                            end
                            default: begin
                                fault_o <= 1'b1;
                                state_q <= RX_IDLE;
                            end
                        endcase
                    end

                    RX_LEN: begin
                        if (!len_lo_q) begin
                            pay_cnt_q[15:8] <= fifo_data_i;
                            len_lo_q        <= 1'b1;
                        end else begin
                            pay_cnt_q[7:0] <= fifo_data_i;
                            if (full_len != '0) begin
                                state_q <= RX_PAYLOAD;
                            end else begin
                                state_q     <= RX_CMD;
                                test_done_o <= (cmd_q == FPGA_STOPPED);
                            end
                        end
                    end

                    RX_PAYLOAD: begin
                        first_q <= 1'b0;
                        if ((cmd_q == FPGA_DATA) && (fifo_data_i != exp_q)) begin
                            fault_o <= 1'b1;
                            state_q <= RX_IDLE;
                        end else begin
                            if (cmd_q == FPGA_DATA) begin
                                exp_q <= exp_q + 8'd1;
                            end
                            if ((cmd_q == FPGA_STOPPED) && first_q) begin
                                error_code_o <= fifo_data_i;
                            end
                            pay_cnt_q <= pay_cnt_q - 16'd1;
                            if (pay_cnt_q == 16'd1) begin
                                state_q     <= RX_CMD;
                                test_done_o <= (cmd_q == FPGA_STOPPED);
                            end
                        end
                    end

                    default: begin
                        // Closed until the next start
                        state_q <= RX_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

/* hdl/ft_host_tx.sv */
// Host-to-FPGA byte stream of the FT2232 model.
// Stream: start, test number, length (2), count (2), packets, stop.
// Packets are only sent when with_data_i is high; every stream ends in stop.
// The byte on tx_byte_o is valid while RXF# is low and advances on each
// edge with OE#, RD# and RXF# all low. RD# high holds the current byte.
// abort_i or stopped_i ends the stream at once; start_i overrides both.

`timescale 1ns/10ps

module ft_host_tx
    import ft_sim_pkg::*;
(
    input  logic  fifo_clk_o,
    input  logic  ft2232_reset_n_i,
    input  logic  start_i,
    input  test_e test_number_i,
    input  len_t  packet_payload_i,
    input  len_t  packet_count_i,
    input  logic  with_data_i,
    input  logic  abort_i,
    input  logic  stopped_i,
    input  logic  fifo_oe_n_i,
    input  logic  fifo_rd_n_i,
    output logic  fifo_rxf_n_o,
    output byte_t tx_byte_o
);

    typedef enum logic [3:0] {
        TX_IDLE,
        TX_START_CMD,
        TX_TEST_NUM,
        TX_LEN_HI,
        TX_LEN_LO,
        TX_CNT_HI,
        TX_CNT_LO,
        TX_DATA_CMD,
        TX_PLEN_HI,
        TX_PLEN_LO,
        TX_PAYLOAD,
        TX_STOP_CMD
    } tx_state_e;

    tx_state_e state_q;
    len_t      pay_cnt_q;
    len_t      pkt_cnt_q;
    byte_t     data_q;
    logic      rd_en;

    // Bytes remain in every state but idle
    assign fifo_rxf_n_o = (state_q == TX_IDLE);
    assign rd_en        = !fifo_oe_n_i && !fifo_rd_n_i && !fifo_rxf_n_o;

    // ======================================================================
    // Byte for the current state
    // ======================================================================
    always_comb begin
        case (state_q)
            TX_START_CMD: tx_byte_o = {HOST_START, START_ARG};
            TX_TEST_NUM:  tx_byte_o = test_number_i;
            TX_LEN_HI:    tx_byte_o = packet_payload_i[15:8];
            TX_LEN_LO:    tx_byte_o = packet_payload_i[7:0];
            TX_CNT_HI:    tx_byte_o = packet_count_i[15:8];
            TX_CNT_LO:    tx_byte_o = packet_count_i[7:0];
            TX_DATA_CMD:  tx_byte_o = {HOST_DATA, LEN_FOLLOWS};
            TX_PLEN_HI:   tx_byte_o = packet_payload_i[15:8];
            TX_PLEN_LO:   tx_byte_o = packet_payload_i[7:0];
            TX_PAYLOAD:   tx_byte_o = data_q;
            TX_STOP_CMD:  tx_byte_o = {HOST_STOP, {CMD_ARG_W{1'b0}}};
            default:      tx_byte_o = '0;
        endcase
    end

    // ======================================================================
    // Stream sequencer
    // ======================================================================
    always_ff @(posedge fifo_clk_o or negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            state_q   <= TX_IDLE;
            pay_cnt_q <= '0;
            pkt_cnt_q <= '0;
            data_q    <= '0;
        end else if (start_i) begin
            state_q   <= TX_START_CMD;
            pkt_cnt_q <= packet_count_i;
            data_q    <= '0;
        end else if (abort_i || stopped_i) begin
            state_q <= TX_IDLE;
        end else if (rd_en) begin
            case (state_q)
                TX_START_CMD: state_q <= TX_TEST_NUM;
                TX_TEST_NUM:  state_q <= TX_LEN_HI;
                TX_LEN_HI:    state_q <= TX_LEN_LO;
                TX_LEN_LO:    state_q <= TX_CNT_HI;
                TX_CNT_HI:    state_q <= TX_CNT_LO;
                TX_CNT_LO: begin
                    if (with_data_i && (pkt_cnt_q != '0)) begin
                        state_q <= TX_DATA_CMD;
                    end else begin
                        state_q <= TX_STOP_CMD;
                    end
                end
                TX_DATA_CMD:  state_q <= TX_PLEN_HI;
                TX_PLEN_HI:   state_q <= TX_PLEN_LO;
                TX_PLEN_LO: begin
                    pay_cnt_q <= packet_payload_i;
                    if (packet_payload_i != '0) begin
                        state_q <= TX_PAYLOAD;
                    end else begin
                        // Empty packet, go straight to the next one
                        pkt_cnt_q <= pkt_cnt_q - 16'd1;
                        state_q   <= (pkt_cnt_q == 16'd1) ? TX_STOP_CMD : TX_DATA_CMD;
                    end
                end
                TX_PAYLOAD: begin
                    // Counting byte keeps running across packets
                    data_q    <= data_q + 8'd1;
                    pay_cnt_q <= pay_cnt_q - 16'd1;
                    if (pay_cnt_q == 16'd1) begin
                        pkt_cnt_q <= pkt_cnt_q - 16'd1;
                        state_q   <= (pkt_cnt_q == 16'd1) ? TX_STOP_CMD : TX_DATA_CMD;
                    end
                end
                TX_STOP_CMD:  state_q <= TX_IDLE;
                default:      state_q <= TX_IDLE;
            endcase
        end
    end

endmodule

/* hdl/ft_sim_cfg.sv */
// Test setup registers for the host model.
// The setup is taken on a cfg_load_i strobe and held until the next one.
// start_o pulses for one cycle after each load and restarts both directions.
// Holding cfg_load_i high keeps restarting the run.

`timescale 1ns/10ps

module ft_sim_cfg
    import ft_sim_pkg::*;
(
    input  logic  fifo_clk_o,
    input  logic  ft2232_reset_n_i,
    input  logic  cfg_load_i,
    input  test_e test_number_i,
    input  len_t  packet_payload_i,
    input  len_t  packet_count_i,
    output test_e test_number_o,
    output len_t  packet_payload_o,
    output len_t  packet_count_o,
    output logic  with_data_o,
    output logic  start_o
);

    // Test setup, held until the next load
    always_ff @(posedge fifo_clk_o) begin
        if (cfg_load_i) begin
            test_number_o    <= test_number_i;
            packet_payload_o <= packet_payload_i;
            packet_count_o   <= packet_count_i;
        end
    end

    // ======================================================================
    // Start pulse and data-phase decode
    // ======================================================================
    always_ff @(posedge fifo_clk_o or negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            with_data_o <= 1'b0;
            start_o     <= 1'b0;
        end else begin
            start_o <= cfg_load_i;
            if (cfg_load_i) begin
                // Receive tests carry host data packets
                with_data_o <= (test_number_i == TEST_RECEIVE) ||
                               (test_number_i == TEST_RECEIVE_SEND);
            end
        end
    end

endmodule

/* hdl/ft_sim_pkg.sv */
// Shared types and encodings for the FT2232 host-side model.
// A command byte carries the opcode in bits 7..5 and an argument in bits 4..0.
// Sixteen-bit lengths and counts go over the bus high byte first.
// Lengths of zero are legal and mean an empty payload.

package ft_sim_pkg;

    // ======================================================================
    // Widths and basic types
    // ======================================================================
    localparam int BYTE_W = 8;
    localparam int LEN_W  = 16;

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [LEN_W-1:0]  len_t;

    // Argument field below the 3-bit opcode
    localparam int CMD_ARG_W = 5;

    // ======================================================================
    // Opcodes
    // ======================================================================

    // Host to FPGA
    typedef enum logic [2:0] {
        HOST_START = 3'd1,
        HOST_DATA  = 3'd2,
        HOST_STOP  = 3'd3
    } host_cmd_e;

    // FPGA to host
    typedef enum logic [2:0] {
        FPGA_DATA     = 3'd4,
        FPGA_LOOPBACK = 3'd5,
        FPGA_STOPPED  = 3'd6
    } fpga_cmd_e;

    // Test numbers sent as the first start payload byte
    typedef enum logic [7:0] {
        TEST_RECEIVE      = 8'd1,
        TEST_SEND         = 8'd2,
        TEST_RECEIVE_SEND = 8'd3
    } test_e;

    // Fixed argument of the start command
    localparam logic [CMD_ARG_W-1:0] START_ARG = 5'd5;

    // Bit 4 of the argument set: two length bytes follow the command
    localparam logic [CMD_ARG_W-1:0] LEN_FOLLOWS = 5'b10000;

endpackage

/* hdl/ft_sim_top.sv */
// Host-side FT2232 synchronous FIFO model, top level.
// The clock comes in on fifo_clk_o, named after the chip's CLKOUT pin.
// The model drives the data bus only while OE# is low.
// SIWU is accepted for pin compatibility and has no effect.
// A run starts two cycles after cfg_load_i, when RXF# goes low.

`timescale 1ns/10ps

module ft_sim_top
    import ft_sim_pkg::*;
(
    input  logic              fifo_clk_o,
    input  logic              ft2232_reset_n_i,
    input  logic              cfg_load_i,
    input  test_e             test_number_i,
    input  len_t              packet_payload_i,
    input  len_t              packet_count_i,
    input  logic              fifo_oe_n_i,
    // Send-immediate request, not modelled
    input  logic              fifo_siwu_i,
    input  logic              fifo_wr_n_i,
    input  logic              fifo_rd_n_i,
    inout  wire  [BYTE_W-1:0] fifo_data_io,
    output logic              fifo_txe_n_o,
    output logic              fifo_rxf_n_o,
    output logic              test_done_o,
    output logic              fault_o,
    output byte_t             error_code_o
);

    test_e test_number;
    len_t  packet_payload;
    len_t  packet_count;
    logic  with_data;
    logic  start;
    logic  abort;
    logic  stopped;
    byte_t tx_byte;

    // Host drives the bus only while the FPGA has OE# low
    assign fifo_data_io = fifo_oe_n_i ? {BYTE_W{1'bz}} : tx_byte;

    // ======================================================================
    // Blocks
    // ======================================================================
    ft_sim_cfg i_ft_sim_cfg (
        .fifo_clk_o       (fifo_clk_o),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .cfg_load_i       (cfg_load_i),
        .test_number_i    (test_number_i),
        .packet_payload_i (packet_payload_i),
        .packet_count_i   (packet_count_i),
        .test_number_o    (test_number),
        .packet_payload_o (packet_payload),
        .packet_count_o   (packet_count),
        .with_data_o      (with_data),
        .start_o          (start)
    );

    ft_host_tx i_ft_host_tx (
        .fifo_clk_o       (fifo_clk_o),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .start_i          (start),
        .test_number_i    (test_number),
        .packet_payload_i (packet_payload),
        .packet_count_i   (packet_count),
        .with_data_i      (with_data),
        .abort_i          (abort),
        .stopped_i        (stopped),
        .fifo_oe_n_i      (fifo_oe_n_i),
        .fifo_rd_n_i      (fifo_rd_n_i),
        .fifo_rxf_n_o     (fifo_rxf_n_o),
        .tx_byte_o        (tx_byte)
    );

    ft_host_rx i_ft_host_rx (
        .fifo_clk_o       (fifo_clk_o),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .start_i          (start),
        .fifo_oe_n_i      (fifo_oe_n_i),
        .fifo_wr_n_i      (fifo_wr_n_i),
        .fifo_data_i      (fifo_data_io),
        .fifo_txe_n_o     (fifo_txe_n_o),
        .abort_o          (abort),
        .stopped_o        (stopped),
        .test_done_o      (test_done_o),
        .fault_o          (fault_o),
        .error_code_o     (error_code_o)
    );

endmodule

/* src.f */
+incdir+test
hdl/ft_sim_pkg.sv
hdl/ft_sim_cfg.sv
hdl/ft_host_tx.sv
hdl/ft_host_rx.sv
hdl/ft_sim_top.sv
test/tb_ft_sim.sv

/* test/tb_ft_sim_tasks.svh */
// Helpers for the FT2232 host-model testbench, included in the testbench top.
// Bus tasks expect to be called just after the drive delay past a rising edge.
// The FPGA side drives the data bus only while OE# is high.
// The expected host stream is rebuilt here from the command encoding.

`ifndef TB_FT_SIM_TASKS_SVH
`define TB_FT_SIM_TASKS_SVH

typedef byte_t byte_q_t[$];

// ======================================================================
// Reference model of the host-to-FPGA stream
// ======================================================================
function automatic byte_q_t expected_host_stream(input test_e test, input len_t payload,
                                                 input len_t count);
    byte_q_t q;
    byte_t   data;
    int      p;
    int      i;
    data = 8'd0;
    q.push_back({HOST_START, START_ARG});
    q.push_back(test);
    q.push_back(payload[15:8]);
    q.push_back(payload[7:0]);
    q.push_back(count[15:8]);
    q.push_back(count[7:0]);
    // Receive tests carry packets of bytes counting on across packets
    if ((test == TEST_RECEIVE) || (test == TEST_RECEIVE_SEND)) begin
        for (p = 0; p < int'(count); p++) begin
            q.push_back({HOST_DATA, LEN_FOLLOWS});
            q.push_back(payload[15:8]);
            q.push_back(payload[7:0]);
            for (i = 0; i < int'(payload); i++) begin
                q.push_back(data);
                data++;
            end
        end
    end
    q.push_back({HOST_STOP, 5'd0});
    return q;
endfunction

task automatic next_cycle();
    @(posedge fifo_clk_o);
    #2;
endtask

// ======================================================================
// FPGA-side bus tasks
// ======================================================================
task automatic send_fpga_byte(input byte_t b);
    int cycles;
    cycles = 0;
    // Optional idle cycle with WR# high
    if (wr_gaps && ($urandom_range(3) == 0)) begin
        fifo_wr_n_i = 1'b1;
        next_cycle();
    end
    fpga_data   = b;
    fifo_wr_n_i = 1'b0;
    while ((fifo_txe_n_o !== 1'b0) && (cycles < WAIT_LIMIT)) begin
        next_cycle();
        cycles++;
    end
    if (fifo_txe_n_o !== 1'b0) begin
        failure_count++;
        $display("Timeout at %0t: TXE# stayed high, byte %02h was never taken", $time, b);
    end else begin
        next_cycle();
    end
endtask

// Data command and its counting payload
task automatic send_data_cmd(input len_t len, input logic long_form);
    int i;
    if (long_form) begin
        send_fpga_byte({FPGA_DATA, LEN_FOLLOWS});
        send_fpga_byte(len[15:8]);
        send_fpga_byte(len[7:0]);
    end else begin
        send_fpga_byte({FPGA_DATA, 1'b0, len[3:0]});
    end
    for (i = 0; i < int'(len); i++) begin
        send_fpga_byte(fpga_count);
        fpga_count++;
    end
endtask

// ======================================================================
// Compare tasks
// ======================================================================
task automatic check_byte(input byte_t got, input byte_t want, input string what);
    if (got !== want) begin
        mismatch_count++;
        $display("Mismatch at %0t: %s is %02h, expected %02h", $time, what, got, want);
    end
endtask

task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
        mismatch_count++;
        $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
    end
endtask

task automatic check_code(input byte_t got, input byte_t want, input string what);
    if (got !== want) begin
        mismatch_count++;
        $display("Mismatch at %0t: %s is %02h, expected %02h", $time, what, got, want);
    end
endtask

`endif

/* test/tb_ft_sim.sv */
// Testbench for the FT2232 host-side model.
// The testbench plays the FPGA: it reads the host stream and sends commands.
// Inputs change 2 ns after each rising edge; host bytes are sampled at the
// falling edge, where bus and strobes are stable.
// Every wait is bounded, so a stuck DUT ends the run with a failure.

`timescale 1ns/10ps

module tb_ft_sim
    import ft_sim_pkg::*;
();

    localparam int WAIT_LIMIT = 5000;

    logic              fifo_clk_o;
    logic              ft2232_reset_n_i;
    logic              cfg_load_i;
    test_e             test_number_i;
    len_t              packet_payload_i;
    len_t              packet_count_i;
    logic              fifo_oe_n_i;
    logic              fifo_siwu_i;
    logic              fifo_wr_n_i;
    logic              fifo_rd_n_i;
    wire  [BYTE_W-1:0] fifo_data_io;
    logic              fifo_txe_n_o;
    logic              fifo_rxf_n_o;
    logic              test_done_o;
    logic              fault_o;
    byte_t             error_code_o;

    byte_t             fpga_data;
    byte_t             fpga_count;
    logic              wr_gaps;
    int                mismatch_count;
    int                failure_count;
    int                host_index;
    int unsigned       seed_value;

    `include "tb_ft_sim_tasks.svh"

    byte_q_t           expected_q;
    byte_t             stop_code;

    // FPGA side owns the bus while OE# is high
    assign fifo_data_io = fifo_oe_n_i ? fpga_data : {BYTE_W{1'bz}};

    always #10 fifo_clk_o = ~fifo_clk_o;

    ft_sim_top i_ft_sim_top (
        .fifo_clk_o       (fifo_clk_o),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .cfg_load_i       (cfg_load_i),
        .test_number_i    (test_number_i),
        .packet_payload_i (packet_payload_i),
        .packet_count_i   (packet_count_i),
        .fifo_oe_n_i      (fifo_oe_n_i),
        .fifo_siwu_i      (fifo_siwu_i),
        .fifo_wr_n_i      (fifo_wr_n_i),
        .fifo_rd_n_i      (fifo_rd_n_i),
        .fifo_data_io     (fifo_data_io),
        .fifo_txe_n_o     (fifo_txe_n_o),
        .fifo_rxf_n_o     (fifo_rxf_n_o),
        .test_done_o      (test_done_o),
        .fault_o          (fault_o),
        .error_code_o     (error_code_o)
    );

    // ======================================================================
    // Host stream comparison
    // ======================================================================
    always @(negedge fifo_clk_o) begin
        if (ft2232_reset_n_i && !fifo_oe_n_i && !fifo_rd_n_i && !fifo_rxf_n_o) begin
            if (expected_q.size() == 0) begin
                failure_count++;
                $display("Unexpected host byte %02h at %0t after the end of the stream",
                         fifo_data_io, $time);
            end else begin
                check_byte(fifo_data_io, expected_q.pop_front(),
                           $sformatf("host byte %0d", host_index));
            end
            host_index++;
        end
    end

    // Latch a setup; the stream opens two cycles after the strobe
    task automatic load_config(input test_e test, input len_t payload, input len_t count);
        test_number_i    = test;
        packet_payload_i = payload;
        packet_count_i   = count;
        fifo_rd_n_i      = 1'b1;
        cfg_load_i       = 1'b1;
        next_cycle();
        cfg_load_i = 1'b0;
        fpga_count = 8'd0;
        next_cycle();
        check_flag(fifo_rxf_n_o, 1'b0, "RXF# two cycles after load");
    endtask

    task automatic wait_rxf_high(input string what);
        int cycles;
        cycles = 0;
        while ((fifo_rxf_n_o !== 1'b1) && (cycles < WAIT_LIMIT)) begin
            next_cycle();
            cycles++;
        end
        if (fifo_rxf_n_o !== 1'b1) begin
            failure_count++;
            $display("Timeout at %0t: RXF# did not go high %s", $time, what);
        end
    endtask

    task automatic run_host_stream(input test_e test, input len_t payload,
                                   input len_t count, input logic rd_gaps);
        int cycles;
        cycles      = 0;
        host_index  = 0;
        fifo_oe_n_i = 1'b0;
        expected_q  = expected_host_stream(test, payload, count);
        load_config(test, payload, count);
        while ((expected_q.size() != 0) && (cycles < WAIT_LIMIT)) begin
            fifo_rd_n_i = rd_gaps ? ($urandom_range(3) == 0) : 1'b0;
            next_cycle();
            cycles++;
        end
        fifo_rd_n_i = 1'b1;
        if (expected_q.size() != 0) begin
            failure_count++;
            $display("Timeout at %0t: host stream ended with %0d bytes still expected",
                     $time, expected_q.size());
        end
        check_flag(fifo_rxf_n_o, 1'b1, "RXF# after the last host byte");
    endtask

    // ======================================================================
    // Scenarios
    // ======================================================================
    initial begin
        seed_value       = $urandom(32'h50784311);
        fifo_clk_o       = 1'b0;
        ft2232_reset_n_i = 1'b0;
        cfg_load_i       = 1'b0;
        test_number_i    = TEST_SEND;
        packet_payload_i = '0;
        packet_count_i   = '0;
        fifo_oe_n_i      = 1'b1;
        fifo_siwu_i      = 1'b1;
        fifo_wr_n_i      = 1'b1;
        fifo_rd_n_i      = 1'b1;
        fpga_data        = '0;
        fpga_count       = '0;
        wr_gaps          = 1'b0;
        mismatch_count   = 0;
        failure_count    = 0;
        host_index       = 0;
        repeat (4) @(posedge fifo_clk_o);
        #2;
        ft2232_reset_n_i = 1'b1;

        check_flag(fifo_rxf_n_o, 1'b1, "RXF# after reset");
        check_flag(fifo_txe_n_o, 1'b0, "TXE# after reset");
        check_flag(test_done_o, 1'b0, "test done after reset");
        check_flag(fault_o, 1'b0, "fault after reset");
        check_code(error_code_o, 8'h00, "error code after reset");

        // Send test: header only, then stop
        run_host_stream(TEST_SEND, 16'h0123, 16'h0456, 1'b0);

        // Receive tests with packets and random read gaps
        run_host_stream(TEST_RECEIVE, 16'd100, 16'd4, 1'b1);
        run_host_stream(TEST_RECEIVE_SEND, 16'd3, 16'd2, 1'b1);

        // Short and long data commands, then stopped with a code
        fifo_oe_n_i = 1'b1;
        wr_gaps     = 1'b1;
        load_config(TEST_SEND, 16'd8, 16'd1);
        send_data_cmd(16'd5, 1'b0);
        send_data_cmd(16'd300, 1'b1);
        check_flag(fault_o, 1'b0, "fault after good data");
        stop_code = 8'($urandom);
        send_fpga_byte({FPGA_STOPPED, 5'd3});
        send_fpga_byte(stop_code);
        send_fpga_byte(8'($urandom));
        send_fpga_byte(8'($urandom));
        fifo_wr_n_i = 1'b1;
        check_flag(test_done_o, 1'b1, "test done after stopped");
        check_code(error_code_o, stop_code, "error code");
        check_flag(fault_o, 1'b0, "fault after stopped");
        wait_rxf_high("after the stopped command");

        // Wrong data byte
        load_config(TEST_RECEIVE, 16'd4, 16'd2);
        send_data_cmd(16'd2, 1'b0);
        send_fpga_byte({FPGA_DATA, 5'd2});
        send_fpga_byte(fpga_count);
        send_fpga_byte(fpga_count + 8'd3);
        fifo_wr_n_i = 1'b1;
        check_flag(fault_o, 1'b1, "fault after wrong data byte");
        wait_rxf_high("after a data fault");
        check_flag(fifo_txe_n_o, 1'b1, "TXE# after data fault");

        // Loopback is ignored, an unknown opcode is not
        load_config(TEST_SEND, 16'd2, 16'd2);
        send_fpga_byte({FPGA_LOOPBACK, 5'd6});
        repeat (6) send_fpga_byte(8'($urandom));
        check_flag(fault_o, 1'b0, "fault after loopback");
        send_data_cmd(16'd3, 1'b0);
        check_flag(fault_o, 1'b0, "fault after data following loopback");
        send_fpga_byte({3'd7, 5'($urandom)});
        fifo_wr_n_i = 1'b1;
        check_flag(fault_o, 1'b1, "fault after unknown opcode");
        check_flag(fifo_txe_n_o, 1'b1, "TXE# after unknown opcode");

        $display("Closing: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if ((mismatch_count == 0) && (failure_count == 0)) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
